//--- hw/memAccessPkg.sv
`default_nettype none

package memAccessPkg;

    ////////////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////////////

    localparam int dataWidth = 32;
    localparam int byteWidth = 8;
    localparam int halfWidth = 16;
    // Byte lanes per word
    localparam int laneCount = dataWidth / byteWidth;

    ////////////////////////////////////////////////////////////////////
    // Access kinds
    ////////////////////////////////////////////////////////////////////

    // Signed kinds sign-extend on load, U kinds zero-extend
    typedef enum logic [2:0] {
        accWord  = 3'd0,
        accHalf  = 3'd1,
        accHalfU = 3'd2,
        accByte  = 3'd3,
        accByteU = 3'd4
    } accessKind;

    ////////////////////////////////////////////////////////////////////
    // Payloads carried by the skid buffers
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                 write;
        accessKind            kind;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic [dataWidth-1:0] pc;
    } memRequest;

    typedef struct packed {
        logic [dataWidth-1:0] rdata;
        logic                 error;
        logic [dataWidth-1:0] pc;
    } memResponse;

endpackage

`default_nettype wire

//--- hw/memMapPkg.sv
`default_nettype none

package memMapPkg;

    ////////////////////////////////////////////////////////////////////
    // RAM geometry
    ////////////////////////////////////////////////////////////////////

    localparam int wordIndexBits = 10;
    localparam int ramWords = 2 ** wordIndexBits;

    ////////////////////////////////////////////////////////////////////
    // Address layout
    ////////////////////////////////////////////////////////////////////

    // Byte within the word sits in the lowest bits
    localparam int byteOffsetBits = 2;

    // Word index directly above the byte offset
    localparam int indexLsb = byteOffsetBits;
    localparam int indexMsb = indexLsb + wordIndexBits - 1;

    // Bits above indexMsb are ignored, so the address space wraps

endpackage

`default_nettype wire

//--- hw/skidBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module skidBuffer #(
    parameter type payloadType = logic [31:0]
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic inValid,
    output logic      inReady,
    input  payloadType inData,
    output logic      outValid,
    input  wire logic outReady,
    output payloadType outData
);

    // Main entry drives the output, skid entry catches a stalled beat
    payloadType mainData;
    payloadType skidData;
    logic       mainValid;
    logic       skidValid;
    logic       inAccept;
    logic       mainFree;

    // Ready only looks at local state, never at inValid
    assign inReady  = !skidValid;
    assign inAccept = inValid && inReady;
    assign mainFree = !mainValid || outReady;

    assign outValid = mainValid;
    assign outData  = mainData;

    always_ff @(posedge clk) begin
        if (reset) begin
            mainValid <= 1'b0;
            skidValid <= 1'b0;
        end else if (mainFree) begin
            // Skid entry drains first to keep order
            if (skidValid) begin
                skidValid <= 1'b0;
                mainValid <= 1'b1;
            end else begin
                mainValid <= inAccept;
            end
        end else if (inAccept) begin
            skidValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mainFree) begin
            mainData <= skidValid ? skidData : inData;
        end
        if (!mainFree && inAccept) begin
            skidData <= inData;
        end
    end

    // A stalled output must hold its payload
    assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(outData));

endmodule

`default_nettype wire

//--- hw/storeAlign.sv
`timescale 1ns/1ps
`default_nettype none

module storeAlign (
    input  memAccessPkg::memRequest request,
    output logic                    misaligned,
    output logic [memAccessPkg::laneCount-1:0]     byteEnable,
    output logic [memAccessPkg::dataWidth-1:0]     laneData,
    output logic [memMapPkg::wordIndexBits-1:0]    wordIndex,
    output logic [memMapPkg::byteOffsetBits-1:0]   byteOffset
);

    import memAccessPkg::*;
    import memMapPkg::*;

    logic [laneCount-1:0] kindMask;

    assign wordIndex  = request.addr[indexMsb:indexLsb];
    assign byteOffset = request.addr[byteOffsetBits-1:0];

    ////////////////////////////////////////////////////////////////////
    // Alignment check
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (request.kind)
            accWord: begin
                misaligned = byteOffset != '0;
            end
            accHalf, accHalfU: begin
                misaligned = byteOffset[0];
            end
            accByte, accByteU: begin
                misaligned = 1'b0;
            end
            // Unknown encodings are flagged like a bad address
            default: begin
                misaligned = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Lane placement and enables
    ////////////////////////////////////////////////////////////////////

    // Store data is replicated over all lanes, the mask picks the right ones
    always_comb begin
        case (request.kind)
            accHalf, accHalfU: begin
                laneData = {2{request.wdata[halfWidth-1:0]}};
                kindMask = byteOffset[1] ? 4'b1100 : 4'b0011;
            end
            accByte, accByteU: begin
                laneData = {4{request.wdata[byteWidth-1:0]}};
                kindMask = 4'b0001 << byteOffset;
            end
            default: begin
                laneData = request.wdata;
                kindMask = 4'b1111;
            end
        endcase
    end

    // Loads and bad addresses touch nothing
    assign byteEnable = (request.write && !misaligned) ? kindMask : '0;

endmodule

`default_nettype wire

//--- hw/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic opValid,
    output logic      opReady,
    input  wire logic write,
    input  wire logic [memAccessPkg::laneCount-1:0]   byteEnable,
    input  wire logic [memAccessPkg::dataWidth-1:0]   laneData,
    input  wire logic [memMapPkg::wordIndexBits-1:0]  wordIndex,
    input  memAccessPkg::accessKind                   kind,
    input  wire logic [memMapPkg::byteOffsetBits-1:0] byteOffset,
    input  wire logic misaligned,
    input  wire logic [memAccessPkg::dataWidth-1:0]   pc,
    output logic      resValid,
    input  wire logic resReady,
    output logic [memAccessPkg::dataWidth-1:0]        resWord,
    output memAccessPkg::accessKind                   resKind,
    output logic [memMapPkg::byteOffsetBits-1:0]      resOffset,
    output logic      resMisaligned,
    output logic [memAccessPkg::dataWidth-1:0]        resPc
);

    import memAccessPkg::*;
    import memMapPkg::*;

    logic [dataWidth-1:0] mem [ramWords];
    logic [dataWidth-1:0] mergedWord;
    logic                 opAccept;

    // Result register free or leaving this cycle
    assign opReady  = !resValid || resReady;
    assign opAccept = opValid && opReady;

    // Old word with the enabled lanes replaced
    always_comb begin
        mergedWord = mem[wordIndex];
        for (int lane = 0; lane < laneCount; lane++) begin
            if (byteEnable[lane]) begin
                mergedWord[lane*byteWidth +: byteWidth] = laneData[lane*byteWidth +: byteWidth];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < ramWords; w++) begin
                mem[w] <= '0;
            end
        end else if (opAccept && write) begin
            mem[wordIndex] <= mergedWord;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            resValid <= 1'b0;
        end else if (opAccept) begin
            resValid <= 1'b1;
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    // Stores return the word as it reads after the write
    always_ff @(posedge clk) begin
        if (opAccept) begin
            resWord       <= mergedWord;
            resKind       <= kind;
            resOffset     <= byteOffset;
            resMisaligned <= misaligned;
            resPc         <= pc;
        end
    end

    // The aligner must never enable lanes for a load
    assert property (@(posedge clk) disable iff (reset)
        opValid && !write |-> byteEnable == '0);

endmodule

`default_nettype wire

//--- hw/loadExtend.sv
`timescale 1ns/1ps
`default_nettype none

module loadExtend (
    input  wire logic [memAccessPkg::dataWidth-1:0]   word,
    input  memAccessPkg::accessKind                   kind,
    input  wire logic [memMapPkg::byteOffsetBits-1:0] byteOffset,
    input  wire logic misaligned,
    input  wire logic [memAccessPkg::dataWidth-1:0]   pc,
    output memAccessPkg::memResponse                  response
);

    import memAccessPkg::*;

    logic [halfWidth-1:0] halfVal;
    logic [byteWidth-1:0] byteVal;
    logic [dataWidth-1:0] extended;

    // Lane select, little endian
    assign halfVal = byteOffset[1] ? word[dataWidth-1:halfWidth] : word[halfWidth-1:0];
    assign byteVal = word[byteOffset*byteWidth +: byteWidth];

    always_comb begin
        case (kind)
            accWord: begin
                extended = word;
            end
            accHalf: begin
                extended = {{(dataWidth-halfWidth){halfVal[halfWidth-1]}}, halfVal};
            end
            accHalfU: begin
                extended = {{(dataWidth-halfWidth){1'b0}}, halfVal};
            end
            accByte: begin
                extended = {{(dataWidth-byteWidth){byteVal[byteWidth-1]}}, byteVal};
            end
            accByteU: begin
                extended = {{(dataWidth-byteWidth){1'b0}}, byteVal};
            end
            default: begin
                extended = '0;
            end
        endcase
    end

    // Bad access gives zero data and the error flag
    assign response = '{
        rdata: misaligned ? '0 : extended,
        error: misaligned,
        pc:    pc
    };

endmodule

`default_nettype wire

//--- hw/dataMemUnit.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemUnit (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic reqValid,
    output logic      reqReady,
    input  wire logic reqWrite,
    input  memAccessPkg::accessKind                 reqKind,
    input  wire logic [memAccessPkg::dataWidth-1:0] reqAddr,
    input  wire logic [memAccessPkg::dataWidth-1:0] reqWdata,
    input  wire logic [memAccessPkg::dataWidth-1:0] reqPc,
    output logic      respValid,
    input  wire logic respReady,
    output logic [memAccessPkg::dataWidth-1:0]      respData,
    output logic      respError,
    output logic [memAccessPkg::dataWidth-1:0]      respPc
);

    import memAccessPkg::*;
    import memMapPkg::*;

    memRequest  reqPayload;
    memRequest  alignedReq;
    logic       alignedValid;
    logic       alignedReady;

    logic                      misaligned;
    logic [laneCount-1:0]      byteEnable;
    logic [dataWidth-1:0]      laneData;
    logic [wordIndexBits-1:0]  wordIndex;
    logic [byteOffsetBits-1:0] byteOffset;

    logic                      resValid;
    logic                      resReady;
    logic [dataWidth-1:0]      resWord;
    accessKind                 resKind;
    logic [byteOffsetBits-1:0] resOffset;
    logic                      resMisaligned;
    logic [dataWidth-1:0]      resPc;

    memResponse extResp;
    memResponse outResp;

    ////////////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////////////

    assign reqPayload = '{
        write: reqWrite,
        kind:  reqKind,
        addr:  reqAddr,
        wdata: reqWdata,
        pc:    reqPc
    };

    skidBuffer #(.payloadType(memRequest)) inBuf (
        .clk      (clk),
        .reset    (reset),
        .inValid  (reqValid),
        .inReady  (reqReady),
        .inData   (reqPayload),
        .outValid (alignedValid),
        .outReady (alignedReady),
        .outData  (alignedReq)
    );

    storeAlign aligner (
        .request    (alignedReq),
        .misaligned (misaligned),
        .byteEnable (byteEnable),
        .laneData   (laneData),
        .wordIndex  (wordIndex),
        .byteOffset (byteOffset)
    );

    ////////////////////////////////////////////////////////////////////
    // RAM and response side
    ////////////////////////////////////////////////////////////////////

    dataRam ram (
        .clk           (clk),
        .reset         (reset),
        .opValid       (alignedValid),
        .opReady       (alignedReady),
        .write         (alignedReq.write),
        .byteEnable    (byteEnable),
        .laneData      (laneData),
        .wordIndex     (wordIndex),
        .kind          (alignedReq.kind),
        .byteOffset    (byteOffset),
        .misaligned    (misaligned),
        .pc            (alignedReq.pc),
        .resValid      (resValid),
        .resReady      (resReady),
        .resWord       (resWord),
        .resKind       (resKind),
        .resOffset     (resOffset),
        .resMisaligned (resMisaligned),
        .resPc         (resPc)
    );

    loadExtend extender (
        .word       (resWord),
        .kind       (resKind),
        .byteOffset (resOffset),
        .misaligned (resMisaligned),
        .pc         (resPc),
        .response   (extResp)
    );

    skidBuffer #(.payloadType(memResponse)) outBuf (
        .clk      (clk),
        .reset    (reset),
        .inValid  (resValid),
        .inReady  (resReady),
        .inData   (extResp),
        .outValid (respValid),
        .outReady (respReady),
        .outData  (outResp)
    );

    assign respData  = outResp.rdata;
    assign respError = outResp.error;
    assign respPc    = outResp.pc;

endmodule

`default_nettype wire

//--- sim/dataMemUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemUnitTb;

    import memAccessPkg::*;

    localparam int vecCount      = 36;
    localparam int fieldCount    = 7;
    localparam int timeoutCycles = 200;
    localparam int resetCycles   = 16;
    localparam int drainCycles   = 20;

    // Column order within one golden vector
    localparam int fWrite    = 0;
    localparam int fKind     = 1;
    localparam int fAddr     = 2;
    localparam int fWdata    = 3;
    localparam int fPc       = 4;
    localparam int fExpData  = 5;
    localparam int fExpError = 6;

    logic                 clk;
    logic                 reset;
    logic                 reqValid;
    logic                 reqReady;
    logic                 reqWrite;
    accessKind            reqKind;
    logic [dataWidth-1:0] reqAddr;
    logic [dataWidth-1:0] reqWdata;
    logic [dataWidth-1:0] reqPc;
    logic                 respValid;
    logic                 respReady = 1'b0;
    logic [dataWidth-1:0] respData;
    logic                 respError;
    logic [dataWidth-1:0] respPc;

    logic [31:0] golden [vecCount*fieldCount];
    logic [7:0]  lfsr = 8'd16;
    int          passCount = 0;
    int          failCount = 0;
    bit          timedOut = 1'b0;
    bit          checkDone = 1'b0;

    dataMemUnit UUT (
        .clk       (clk),
        .reset     (reset),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .reqWrite  (reqWrite),
        .reqKind   (reqKind),
        .reqAddr   (reqAddr),
        .reqWdata  (reqWdata),
        .reqPc     (reqPc),
        .respValid (respValid),
        .respReady (respReady),
        .respData  (respData),
        .respError (respError),
        .respPc    (respPc)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Response back-pressure
    //////////////////////////////////////////////////////////////////////

    // Galois form, taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] stepLfsr(input logic [7:0] state);
        logic [7:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 8'hB8;
        end
        return next;
    endfunction

    // Two fresh bits per cycle, ready drops when both are zero
    always @(posedge clk) begin : readyGen
        logic [1:0] pick;
        lfsr = stepLfsr(lfsr);
        pick[0] = lfsr[0];
        lfsr = stepLfsr(lfsr);
        pick[1] = lfsr[0];
        if (reset) begin
            respReady <= 1'b1;
        end else begin
            respReady <= (pick != 2'b00);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkData(input string name, input logic [dataWidth-1:0] expected,
                             input logic [dataWidth-1:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("ERROR %s data: expected %h, actual %h", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic checkError(input string name, input logic expected,
                              input logic actual, inout bit ok);
        if (actual !== expected) begin
            $display("ERROR %s error flag: expected %b, actual %b", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic checkPc(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("ERROR %s pc: expected %h, actual %h", name, expected, actual);
            ok = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////////

    task automatic driveRequest(input int vec);
        int base;
        base = vec * fieldCount;
        reqValid <= 1'b1;
        reqWrite <= golden[base+fWrite][0];
        reqKind  <= accessKind'(golden[base+fKind][2:0]);
        reqAddr  <= golden[base+fAddr];
        reqWdata <= golden[base+fWdata];
        reqPc    <= golden[base+fPc];
    endtask

    // Returns on the edge where the request transfers
    task automatic awaitAccept(input int vec);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!reqReady && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!reqReady) begin
            $display("Timeout: request vec%0d was never accepted", vec);
            timedOut = 1'b1;
        end
        @(posedge clk);
    endtask

    // Nothing may come out once every vector has been answered
    task automatic checkNoExtra();
        int waited;
        waited = 0;
        while (waited < drainCycles) begin
            @(negedge clk);
            if (respValid) begin
                $display("Unexpected extra response with pc %h", respPc);
                failCount++;
                break;
            end
            waited++;
        end
    endtask

    initial begin : stimulus
        int waited;
        clk      = 1'b0;
        reset    = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqKind  = accWord;
        reqAddr  = '0;
        reqWdata = '0;
        reqPc    = '0;
        $readmemh("sim/memGolden.hex", golden);
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        for (int v = 0; v < vecCount; v++) begin
            driveRequest(v);
            awaitAccept(v);
            if (timedOut) begin
                break;
            end
        end
        reqValid <= 1'b0;

        waited = 0;
        while (!checkDone && waited < timeoutCycles) begin
            @(posedge clk);
            waited++;
        end
        if (!checkDone) begin
            $display("Timeout: responses still missing after the last request");
            timedOut = 1'b1;
        end else begin
            checkNoExtra();
        end

        $display("Vectors checked: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////////////////////////

    // Responses must arrive in issue order, so vector v pairs with the v-th response
    initial begin : responseChecker
        int    waited;
        int    base;
        bit    ok;
        string name;
        for (int v = 0; v < vecCount; v++) begin
            base = v * fieldCount;
            name = $sformatf("vec%0d", v);
            waited = 0;
            @(negedge clk);
            while (!(respValid && respReady) && waited < timeoutCycles) begin
                @(negedge clk);
                waited++;
            end
            if (!(respValid && respReady)) begin
                $display("Timeout: no response arrived for %s", name);
                timedOut = 1'b1;
                break;
            end
            ok = 1'b1;
            checkData(name, golden[base+fExpData], respData, ok);
            checkError(name, golden[base+fExpError][0], respError, ok);
            checkPc(name, golden[base+fPc], respPc, ok);
            if (ok) begin
                passCount++;
            end else begin
                failCount++;
            end
            $display("%s pc %h data %h error %0d : %s", name, respPc, respData,
                     respError, ok ? "ok" : "mismatch");
            // Transfer completes on this edge
            @(posedge clk);
        end
        checkDone = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/memGolden.hex
// write kind addr wdata pc expData expError
// kind: 0 word, 1 half, 2 half unsigned, 3 byte, 4 byte unsigned
0 0 00000010 00000000 00001000 00000000 0
1 0 00000010 12345678 00001004 12345678 0
0 0 00000010 00000000 00001008 12345678 0
1 2 00000012 0000abcd 0000100c 0000abcd 0
0 0 00000010 00000000 00001010 abcd5678 0
1 4 00000011 000000ee 00001014 000000ee 0
0 0 00000010 00000000 00001018 abcdee78 0
1 3 00000010 00000099 0000101c ffffff99 0
0 0 00000010 00000000 00001020 abcdee99 0
0 1 00000012 00000000 00001024 ffffabcd 0
0 2 00000012 00000000 00001028 0000abcd 0
0 3 00000011 00000000 0000102c ffffffee 0
0 4 00000011 00000000 00001030 000000ee 0
0 3 00000013 00000000 00001034 ffffffab 0
0 4 00000013 00000000 00001038 000000ab 0
0 1 00000010 00000000 0000103c ffffee99 0
0 2 00000010 00000000 00001040 0000ee99 0
0 3 00000010 00000000 00001044 ffffff99 0
1 0 00000020 7f3e1c05 00001048 7f3e1c05 0
0 1 00000022 00000000 0000104c 00007f3e 0
0 3 00000020 00000000 00001050 00000005 0
1 0 00000021 deadbeef 00001054 00000000 1
1 1 00000023 0000beef 00001058 00000000 1
0 0 00000022 00000000 0000105c 00000000 1
0 2 00000021 00000000 00001060 00000000 1
0 0 00000020 00000000 00001064 7f3e1c05 0
1 0 00001030 cafef00d 00001068 cafef00d 0
0 0 00000030 00000000 0000106c cafef00d 0
1 4 00000033 000000a5 00001070 000000a5 0
0 0 00000030 00000000 00001074 a5fef00d 0
1 2 00000030 12348001 00001078 00008001 0
0 1 00000030 00000000 0000107c ffff8001 0
0 0 00000030 00000000 00001080 a5fe8001 0
0 0 00000ffc 00000000 00001084 00000000 0
1 0 00000ffc 0badf00d 00001088 0badf00d 0
0 4 00000fff 00000000 0000108c 0000000b 0

//--- flist.f
hw/memAccessPkg.sv
hw/memMapPkg.sv
hw/skidBuffer.sv
hw/storeAlign.sv
hw/dataRam.sv
hw/loadExtend.sv
hw/dataMemUnit.sv
sim/dataMemUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dataMemUnitTb
FLIST     := flist.f

SOURCES   := $(shell grep -v '^+' $(FLIST))
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST) sim/memGolden.hex
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
